// ==== hdl/dcache_pkg.sv ====
//****************************************
// Shared definitions of the L1 data cache data stage
// Cache geometry, address fields, access sizes and bus structs
//****************************************

package dcache_pkg;

    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 64;
    localparam int LINE_BYTES = 64;
    localparam int LINE_WORDS = 16;
    localparam int OFFSET_WIDTH = 6;
    localparam int SET_WIDTH = 6;
    localparam int TAG_WIDTH = 20;

    typedef logic [31:0] addr_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [SET_WIDTH-1:0] set_idx_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t;
    typedef logic [31:0] word_t;

    // Byte 0 of a line sits in the top eight bits of the line data
    typedef logic [LINE_BYTES*8-1:0] line_data_t;

    // Bit 0 enables byte 0, the lowest address
    typedef logic [LINE_BYTES-1:0] byte_mask_t;

    typedef logic [1:0] access_size_t;
    localparam access_size_t SIZE_BYTE = 2'd0;
    localparam access_size_t SIZE_HALF = 2'd1;
    localparam access_size_t SIZE_WORD = 2'd2;

    typedef tag_t [NUM_WAYS-1:0] way_tags_t;

    typedef struct packed {
        logic valid;
        logic is_load;
        access_size_t size;
        addr_t paddr;
        word_t store_value;
    } dcache_req_t;

    // One complete line from L2, tag and data together
    typedef struct packed {
        logic en;
        way_idx_t way;
        set_idx_t set;
        tag_t tag;
        line_data_t data;
    } l2_fill_t;

    typedef struct packed {
        logic en;
        addr_t addr;
        byte_mask_t mask;
        line_data_t data;
    } store_req_t;

    typedef struct packed {
        logic en;
        addr_t addr;
    } miss_req_t;

    typedef struct packed {
        logic valid;
        logic rollback;
        logic suspend;
        logic fault;
    } dcache_resp_t;

endpackage

// ==== hdl/tag_match.sv ====
//****************************************
// Tag comparison across all ways of a set
//****************************************

`timescale 1ns/1ps

module tag_match
    import dcache_pkg::*;
(
    input tag_t req_tag,
    input way_tags_t way_tags,
    input way_mask_t way_valid,
    output logic hit,
    output way_idx_t hit_way,
    output way_mask_t way_hit_oh
);

    // All ways compared in parallel
    genvar way;
    generate
        for (way = 0; way < NUM_WAYS; way++)
        begin : way_cmp_gen
            assign way_hit_oh[way] = way_valid[way] && way_tags[way] == req_tag;
        end
    endgenerate

    assign hit = |way_hit_oh;

    // One-hot to index, at most one bit is expected
    always_comb
    begin
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (way_hit_oh[i])
                hit_way = hit_way | way_idx_t'(i);
        end
    end

endmodule

// ==== hdl/store_formatter.sv ====
//****************************************
// Scalar store formatting
// Byte mask, replicated big-endian data and alignment check
//****************************************

`timescale 1ns/1ps

module store_formatter
    import dcache_pkg::*;
(
    input access_size_t size,
    input logic [OFFSET_WIDTH-1:0] offset,
    input word_t store_value,
    output byte_mask_t byte_mask,
    output line_data_t store_data,
    output logic unaligned
);

    logic [3:0] word_byte_mask;
    logic [LINE_WORDS-1:0] word_sel;
    logic [OFFSET_WIDTH-3:0] word_idx;
    word_t swapped_value;

    // Word within the line
    assign word_idx = offset[OFFSET_WIDTH-1:2];
    assign word_sel = {{(LINE_WORDS-1){1'b0}}, 1'b1} << word_idx;

    // Low byte of the value lands at the lowest address
    assign swapped_value = {store_value[7:0], store_value[15:8],
        store_value[23:16], store_value[31:24]};

    always_comb
    begin
        word_byte_mask = 4'b0000;
        store_data = '0;
        unaligned = 1'b0;
        case (size)
            SIZE_BYTE:
            begin
                word_byte_mask = 4'b0001 << offset[1:0];
                store_data = {LINE_BYTES{store_value[7:0]}};
            end
            SIZE_HALF:
            begin
                word_byte_mask = offset[1] ? 4'b1100 : 4'b0011;
                store_data = {(LINE_BYTES / 2){swapped_value[31:16]}};
                unaligned = offset[0];
            end
            SIZE_WORD:
            begin
                word_byte_mask = 4'b1111;
                store_data = {LINE_WORDS{swapped_value}};
                unaligned = |offset[1:0];
            end
            // Undefined size code faults like a misaligned access
            default: unaligned = 1'b1;
        endcase
    end

    genvar b;
    generate
        for (b = 0; b < LINE_BYTES; b++)
        begin : mask_gen
            assign byte_mask[b] = word_sel[b / 4] & word_byte_mask[b % 4];
        end
    endgenerate

endmodule

// ==== hdl/line_data_ram.sv ====
//****************************************
// Cache line storage, one read and one fill port
//****************************************

`timescale 1ns/1ps

module line_data_ram
    import dcache_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic read_en,
    input way_idx_t read_way,
    input set_idx_t read_set,
    output line_data_t read_data,
    input l2_fill_t fill
);

    line_data_t mem [NUM_WAYS * NUM_SETS];
    logic fill_bypass;

    // Same way and set written this cycle, return the new line
    assign fill_bypass = fill.en && fill.way == read_way && fill.set == read_set;

    always_ff @(posedge clk)
    begin
        if (fill.en)
            mem[{fill.way, fill.set}] <= fill.data;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            read_data <= '0;
        else if (read_en)
            read_data <= fill_bypass ? fill.data : mem[{read_way, read_set}];
    end

endmodule

// ==== hdl/access_control.sv ====
//****************************************
// Access qualification and response register
// Miss, store and LRU strobes, data RAM read
//****************************************

`timescale 1ns/1ps

module access_control
    import dcache_pkg::*;
(
    input logic clk,
    input logic reset,
    input dcache_req_t req,
    input logic hit,
    input way_idx_t hit_way,
    input byte_mask_t byte_mask,
    input line_data_t store_data,
    input logic unaligned,
    input l2_fill_t fill,
    output store_req_t store,
    output miss_req_t miss,
    output logic lru_update_en,
    output way_idx_t lru_update_way,
    output dcache_resp_t resp,
    output line_data_t load_data
);

    tag_t req_tag;
    set_idx_t req_set;
    logic load_en;
    logic near_miss;
    logic cache_miss;
    logic ram_read_en;

    assign req_tag = req.paddr[OFFSET_WIDTH + SET_WIDTH +: TAG_WIDTH];
    assign req_set = req.paddr[OFFSET_WIDTH +: SET_WIDTH];
    assign load_en = req.valid && req.is_load;

    // L2 is filling this very line, so a suspend would never be woken
    assign near_miss = load_en && !hit && fill.en
        && fill.set == req_set && fill.tag == req_tag;

    assign cache_miss = load_en && !hit && !near_miss && !unaligned;

    assign miss.en = cache_miss;
    assign miss.addr = {req.paddr[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    assign store.en = req.valid && !req.is_load && !unaligned;
    assign store.addr = req.paddr;
    assign store.mask = byte_mask;
    assign store.data = store_data;

    // Loads and stores both refresh the LRU on a hit
    assign lru_update_en = req.valid && hit && !unaligned;
    assign lru_update_way = hit_way;

    assign ram_read_en = load_en && hit && !unaligned;

    line_data_ram line_data_ram_inst (
        .clk(clk),
        .reset(reset),
        .read_en(ram_read_en),
        .read_way(hit_way),
        .read_set(req_set),
        .read_data(load_data),
        .fill(fill)
    );

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            resp <= '0;
        end
        else
        begin
            resp.valid <= req.valid;
            resp.fault <= req.valid && unaligned;
            // Any load miss retries, near misses included
            resp.rollback <= load_en && !hit;
            resp.suspend <= cache_miss;
        end
    end

endmodule

// ==== hdl/dcache_data_stage.sv ====
//****************************************
// L1 data cache data stage, top level
//****************************************

`timescale 1ns/1ps

module dcache_data_stage
    import dcache_pkg::*;
(
    input logic clk,
    input logic reset,
    input dcache_req_t req,
    input way_tags_t way_tags,
    input way_mask_t way_valid,
    input l2_fill_t fill,
    output store_req_t store,
    output miss_req_t miss,
    output logic lru_update_en,
    output way_idx_t lru_update_way,
    output dcache_resp_t resp,
    output line_data_t load_data
);

    tag_t req_tag;
    logic [OFFSET_WIDTH-1:0] req_offset;
    logic hit;
    way_idx_t hit_way;
    way_mask_t way_hit_oh;
    byte_mask_t byte_mask;
    line_data_t store_data;
    logic unaligned;

    assign req_tag = req.paddr[OFFSET_WIDTH + SET_WIDTH +: TAG_WIDTH];
    assign req_offset = req.paddr[OFFSET_WIDTH-1:0];

    tag_match tag_match_inst (
        .req_tag(req_tag),
        .way_tags(way_tags),
        .way_valid(way_valid),
        .hit(hit),
        .hit_way(hit_way),
        .way_hit_oh(way_hit_oh)
    );

    store_formatter store_formatter_inst (
        .size(req.size),
        .offset(req_offset),
        .store_value(req.store_value),
        .byte_mask(byte_mask),
        .store_data(store_data),
        .unaligned(unaligned)
    );

    access_control access_control_inst (
        .clk(clk),
        .reset(reset),
        .req(req),
        .hit(hit),
        .hit_way(hit_way),
        .byte_mask(byte_mask),
        .store_data(store_data),
        .unaligned(unaligned),
        .fill(fill),
        .store(store),
        .miss(miss),
        .lru_update_en(lru_update_en),
        .lru_update_way(lru_update_way),
        .resp(resp),
        .load_data(load_data)
    );

endmodule

// ==== bench/dcache_data_stage_asserts.sv ====
//****************************************
// Concurrent assertions bound to the data stage
//****************************************

`timescale 1ns/1ps

module dcache_data_stage_asserts
    import dcache_pkg::*;
(
    input logic clk,
    input logic reset,
    input way_mask_t way_hit_oh,
    input store_req_t store,
    input miss_req_t miss
);

    // A tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (reset) $onehot0(way_hit_oh))
        else $error("More than one way hit");

    assert property (@(posedge clk) disable iff (reset) !(store.en && miss.en))
        else $error("Store and miss strobes high together");

    assert property (@(posedge clk) disable iff (reset) store.en |-> store.mask != '0)
        else $error("Store strobe with an empty byte mask");

endmodule

bind dcache_data_stage dcache_data_stage_asserts dcache_data_stage_asserts_inst (
    .clk(clk),
    .reset(reset),
    .way_hit_oh(way_hit_oh),
    .store(store),
    .miss(miss)
);

// ==== bench/dcache_data_stage_tb.sv ====
//****************************************
// Testbench for the data cache data stage
// Stimulus table, reference model, checks and run limit
//****************************************

`timescale 1ns/1ps

module dcache_data_stage_tb
    import dcache_pkg::*;
();

    // A row may fill and request in the same cycle
    localparam int FILL = 1;
    localparam int REQ = 2;
    localparam int BOTH = 3;

    // Fill line defaults to the request's set and tag
    typedef struct {
        string name;
        int kind, way, set, off, is_load;
        tag_t tag;
        access_size_t size;
        word_t value;
        addr_t paddr;
        int fill_set;
        tag_t fill_tag;
    } row_t;

    logic clk;
    logic reset;
    dcache_req_t req;
    way_tags_t way_tags;
    way_mask_t way_valid;
    l2_fill_t fill;
    store_req_t store;
    miss_req_t miss;
    logic lru_update_en;
    way_idx_t lru_update_way;
    dcache_resp_t resp;
    line_data_t load_data;

    row_t rows[$];
    int row_errs[$];
    int total_errors = 0;
    int cycles = 0;
    int limit = 0;
    integer seed = 32'hfd1f;

    // What the tag stage and the data RAM should hold
    line_data_t model_line [NUM_WAYS][NUM_SETS] = '{default: '0};
    tag_t model_tag [NUM_WAYS][NUM_SETS] = '{default: '0};
    logic model_valid [NUM_WAYS][NUM_SETS] = '{default: 1'b0};
    dcache_resp_t exp_resp = '0;
    line_data_t exp_load_data = '0;

    dcache_data_stage dcache_data_stage_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles > limit)
        begin
            $display("Timeout: the run did not end within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic add_row(input string name, input int kind, input int way, input int set,
        input tag_t tag, input int is_load, input access_size_t size, input int off,
        input word_t value);
        row_t r;
        r = '{name, kind, way, set, off, is_load, tag, size, value,
            {tag, set_idx_t'(set), 6'(off)}, set, tag};
        rows.push_back(r);
        row_errs.push_back(0);
    endtask

    // Points the fill of the last row at another line
    task automatic move_fill(input int set, input tag_t tag);
        row_t r;
        r = rows[rows.size()-1];
        r.fill_set = set;
        r.fill_tag = tag;
        rows[rows.size()-1] = r;
    endtask

    task automatic check_that(input logic ok, input int idx, input string what);
        assert (ok)
        else
        begin
            $display("CHECK FAILED at %0t ns: %s, %s", $time, rows[idx].name, what);
            row_errs[idx]++;
            total_errors++;
        end
    endtask

    task automatic drive_row(input int idx);
        row_t r;
        r = rows[idx];
        req = '0;
        fill = '0;
        way_tags = '0;
        way_valid = '0;
        if ((r.kind & FILL) != 0)
        begin
            fill.en = 1'b1;
            fill.way = way_idx_t'(r.way);
            fill.set = set_idx_t'(r.fill_set);
            fill.tag = r.fill_tag;
            for (int k = 0; k < LINE_WORDS; k++)
                fill.data[k*32 +: 32] = $random(seed);
        end
        if ((r.kind & REQ) != 0)
        begin
            req.valid = 1'b1;
            req.is_load = r.is_load != 0;
            req.size = r.size;
            req.paddr = r.paddr;
            req.store_value = r.value;
            // Tag stage view of the addressed set
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                way_tags[w] = model_tag[w][r.set];
                way_valid[w] = model_valid[w][r.set];
            end
        end
    endtask

    // Checks the strobes of this cycle and predicts the next response
    task automatic check_request(input int idx);
        row_t r;
        logic is_req, is_ld, hit, unal, near, cmiss, exp_store, exp_lru;
        way_idx_t hway;
        byte_mask_t mask;
        line_data_t data;
        int width;
        r = rows[idx];
        is_req = (r.kind & REQ) != 0;
        is_ld = is_req && r.is_load != 0;
        hit = 1'b0;
        hway = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (is_req && model_valid[w][r.set] && model_tag[w][r.set] == r.tag)
            begin
                hit = 1'b1;
                hway = way_idx_t'(w);
            end
        end
        // Byte 0 is the top byte of the line
        // Low value byte goes to the lower address
        width = 1 << r.size;
        unal = is_req && (r.off % width) != 0;
        for (int b = 0; b < LINE_BYTES; b++)
        begin
            mask[b] = (b / width) == (r.off / width);
            data[(LINE_BYTES-1-b)*8 +: 8] = r.value[8*(b % width) +: 8];
        end
        near = is_ld && !hit && (r.kind & FILL) != 0
            && r.fill_set == r.set && r.fill_tag == r.tag;
        cmiss = is_ld && !hit && !near && !unal;
        exp_store = is_req && !is_ld && !unal;
        exp_lru = is_req && hit && !unal;
        check_that(miss.en == cmiss, idx, "miss.en wrong");
        if (cmiss)
            check_that(miss.addr == {r.paddr[31:6], 6'b0}, idx, "miss.addr not line-aligned");
        check_that(store.en == exp_store, idx, "store.en wrong");
        if (exp_store)
            check_that(store.addr == r.paddr && store.mask == mask && store.data == data,
                idx, $sformatf("store mask %h, expected %h", store.mask, mask));
        check_that(lru_update_en == exp_lru, idx, "lru_update_en wrong");
        if (exp_lru)
            check_that(lru_update_way == hway, idx, "lru_update_way wrong");
        exp_resp.valid = is_req;
        exp_resp.fault = is_req && unal;
        exp_resp.rollback = is_ld && !hit;
        exp_resp.suspend = cmiss;
        // A fill of the same line in this cycle wins over the stored line
        if (is_ld && hit && !unal)
            exp_load_data = (fill.en && fill.way == hway && fill.set == set_idx_t'(r.set))
                ? fill.data : model_line[hway][r.set];
        if ((r.kind & FILL) != 0)
        begin
            model_line[r.way][r.fill_set] = fill.data;
            model_tag[r.way][r.fill_set] = r.fill_tag;
            model_valid[r.way][r.fill_set] = 1'b1;
        end
    endtask

    task automatic build_table();
        add_row("reset_idle", 0, 0, 0, 20'h0, 0, SIZE_BYTE, 0, 32'h0);
        add_row("fill_w1_s5", FILL, 1, 5, 20'h12345, 0, SIZE_BYTE, 0, 32'h0);
        add_row("fill_w2_s5", FILL, 2, 5, 20'h0abcd, 0, SIZE_BYTE, 0, 32'h0);
        add_row("fill_w0_s9", FILL, 0, 9, 20'h00777, 0, SIZE_BYTE, 0, 32'h0);
        add_row("load_hit_w1", REQ, 0, 5, 20'h12345, 1, SIZE_WORD, 8, 32'h0);
        add_row("load_hit_w2", REQ, 0, 5, 20'h0abcd, 1, SIZE_BYTE, 3, 32'h0);
        add_row("load_miss", REQ, 0, 5, 20'h55555, 1, SIZE_WORD, 36, 32'h0);
        add_row("near_miss", BOTH, 3, 12, 20'h3c3c3, 1, SIZE_WORD, 4, 32'h0);
        add_row("load_hit_w3", REQ, 0, 12, 20'h3c3c3, 1, SIZE_HALF, 6, 32'h0);
        add_row("refill_hit", BOTH, 1, 5, 20'h12345, 1, SIZE_WORD, 16, 32'h0);
        add_row("miss_fill_other_tag", BOTH, 3, 5, 20'h55555, 1, SIZE_WORD, 12, 32'h0);
        move_fill(5, 20'h0f0f0);
        add_row("miss_fill_other_set", BOTH, 2, 5, 20'h55555, 1, SIZE_BYTE, 9, 32'h0);
        move_fill(6, 20'h55555);
        add_row("hit_fill_other_way", BOTH, 0, 5, 20'h12345, 1, SIZE_WORD, 20, 32'h0);
        move_fill(5, 20'h0e0e0);
        add_row("store_byte_hit", REQ, 0, 5, 20'h12345, 0, SIZE_BYTE, 31, 32'h000000a5);
        add_row("store_half_hit", REQ, 0, 5, 20'h0abcd, 0, SIZE_HALF, 34, 32'h0000beef);
        add_row("store_word_miss", REQ, 0, 7, 20'h11111, 0, SIZE_WORD, 60, 32'hdeadbeef);
        add_row("store_byte_miss", REQ, 0, 7, 20'h11111, 0, SIZE_BYTE, 0, 32'h5a5a5a3c);
        add_row("store_half_top", REQ, 0, 9, 20'h00777, 0, SIZE_HALF, 62, 32'h00001234);
        add_row("store_word_hit", REQ, 0, 9, 20'h00777, 0, SIZE_WORD, 20, 32'h01234567);
        add_row("half_odd_store", REQ, 0, 5, 20'h12345, 0, SIZE_HALF, 7, 32'h0000ffff);
        add_row("word_load_off2", REQ, 0, 5, 20'h12345, 1, SIZE_WORD, 2, 32'h0);
        add_row("word_load_miss_off1", REQ, 0, 3, 20'h99999, 1, SIZE_WORD, 1, 32'h0);
        add_row("load_after_fault", REQ, 0, 9, 20'h00777, 1, SIZE_BYTE, 63, 32'h0);
    endtask

    initial
    begin
        int passed;
        passed = 0;
        reset = 1'b1;
        build_table();
        drive_row(0);
        limit = rows.size() * 4 + 100;
        repeat (10) @(posedge clk);
        #1;
        check_that(resp == '0 && load_data == '0 && !store.en && !miss.en && !lru_update_en,
            0, "outputs not cleared by reset");
        reset = 1'b0;
        // One row per cycle with its response checked in the following cycle
        for (int i = 0; i <= rows.size(); i++)
        begin
            drive_row(i < rows.size() ? i : 0);
            #8;
            if (i > 0)
            begin
                check_that(resp == exp_resp, i - 1,
                    $sformatf("resp %b, expected %b", resp, exp_resp));
                check_that(load_data == exp_load_data, i - 1, "load_data differs from model");
                $display("%s: %s", rows[i-1].name, row_errs[i-1] == 0 ? "passed" : "FAILED");
                if (row_errs[i-1] == 0)
                    passed++;
            end
            if (i < rows.size())
                check_request(i);
            @(posedge clk);
            #1;
        end
        $display("Tests: %0d passed, %0d failed, %0d failed checks",
            passed, rows.size() - passed, total_errors);
        if (total_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/dcache_pkg.sv
hdl/tag_match.sv
hdl/store_formatter.sv
hdl/line_data_ram.sv
hdl/access_control.sv
hdl/dcache_data_stage.sv
bench/dcache_data_stage_asserts.sv
bench/dcache_data_stage_tb.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --timing --assert
TOP = dcache_data_stage_tb
FLIST = flist.f
LOG = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
